// ==== common/vdma_params.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, frame geometry and sync timing for the frame buffer test
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef VDMA_PARAMS_SVH
`define VDMA_PARAMS_SVH

`define VDMA_PIX_W        24            // rgb, red on top
`define VDMA_SLOT_W       32            // pixel slot in a memory word
`define VDMA_MEM_DW       128
`define VDMA_PIX_PER_WORD 4
`define VDMA_MEM_AW       28
`define VDMA_ADDR_STEP    8             // address units per word
`define VDMA_FB_BASE      28'h0000400   // frame buffer start

// small test raster
`define VDMA_H_ACTIVE     16
`define VDMA_V_ACTIVE     4
`define VDMA_H_TOTAL      24
`define VDMA_V_TOTAL      6
`define VDMA_HS_START     18
`define VDMA_HS_LEN       3
`define VDMA_VS_LINES     1             // first lines of vertical blanking

`define VDMA_RD_DEPTH     4             // reader buffer, in words

`endif

// ==== common/vdma_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for pixels, memory words and native port commands
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "vdma_params.svh"

package vdma_pkg;

    typedef logic [`VDMA_PIX_W-1:0]    pixel_t;    // {r, g, b}
    typedef logic [`VDMA_MEM_DW-1:0]   mem_word_t; // pixel n in slot n, top byte zero
    typedef logic [`VDMA_MEM_AW-1:0]   mem_addr_t;
    typedef logic [`VDMA_MEM_DW/8-1:0] wr_mask_t;  // zero means write all bytes
    typedef logic [15:0]               coord_t;    // pixel or line index

    // native port command codes
    typedef enum logic [2:0] {
        CMD_WRITE = 3'd0,
        CMD_READ  = 3'd1
    } mem_cmd_e;

endpackage

// ==== rtl/pattern_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// test pattern source, one pixel per transfer once calibration is done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "vdma_params.svh"

module pattern_gen (
    input  logic             app_clk,
    input  logic             rst,
    input  logic             init_calib_complete,
    output logic             pix_valid,
    input  logic             pix_ready,
    output vdma_pkg::pixel_t pix_data
);

    vdma_pkg::coord_t x;    // column
    vdma_pkg::coord_t y;    // line
    logic             pix_fire;

    assign pix_fire = pix_valid && pix_ready;

    // red = line, green = column, blue = inverted column
    assign pix_data = {y[7:0], x[7:0], ~x[7:0]};

    always_ff @(posedge app_clk) begin
        if (rst) begin
            pix_valid <= 1'b0;
            x         <= '0;
            y         <= '0;
        end else begin
            if (init_calib_complete)
                pix_valid <= 1'b1;  // stays up, frames run back to back
            if (pix_fire) begin
                if (x == `VDMA_H_ACTIVE - 1) begin
                    x <= '0;
                    // next line, or wrap to a new frame
                    y <= (y == `VDMA_V_ACTIVE - 1) ? '0 : y + 1'b1;
                end else begin
                    x <= x + 1'b1;
                end
            end
        end
    end

    // a stalled pixel is held until the writer takes it
    assert property (@(posedge app_clk) disable iff (rst)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix_data));

endmodule

// ==== vdma/frame_writer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packs four pixels per word and writes them to the frame buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "vdma_params.svh"

module frame_writer (
    input  logic                app_clk,
    input  logic                rst,
    input  logic                pix_valid,
    output logic                pix_ready,
    input  vdma_pkg::pixel_t    pix_data,
    output logic                wr_req,
    output vdma_pkg::mem_addr_t wr_addr,
    output vdma_pkg::mem_word_t wr_data,
    input  logic                wr_done,
    output logic                frame_written
);

    localparam int SL_W  = $clog2(`VDMA_PIX_PER_WORD);
    localparam int WORDS = `VDMA_H_ACTIVE * `VDMA_V_ACTIVE / `VDMA_PIX_PER_WORD;
    localparam logic [SL_W-1:0]  LAST_SLOT = SL_W'(`VDMA_PIX_PER_WORD - 1);
    localparam vdma_pkg::coord_t LAST_WORD = vdma_pkg::coord_t'(WORDS - 1);

    logic [SL_W-1:0]  slot;     // next slot to fill
    vdma_pkg::coord_t word_idx; // word within the frame
    logic             pix_fire;

    assign pix_ready = !wr_req; // no packing while a write is out
    assign pix_fire  = pix_valid && pix_ready;

    always_ff @(posedge app_clk) begin
        if (rst) begin
            slot          <= '0;
            wr_req        <= 1'b0;
            wr_addr       <= vdma_pkg::mem_addr_t'(`VDMA_FB_BASE);
            word_idx      <= '0;
            frame_written <= 1'b0;
        end else begin
            if (pix_fire) begin
                slot <= (slot == LAST_SLOT) ? '0 : slot + 1'b1;
                if (slot == LAST_SLOT)
                    wr_req <= 1'b1;     // word complete
            end
            if (wr_done) begin
                wr_req <= 1'b0;
                if (word_idx == LAST_WORD) begin
                    word_idx      <= '0;
                    wr_addr       <= vdma_pkg::mem_addr_t'(`VDMA_FB_BASE);
                    frame_written <= 1'b1;  // sticky
                end else begin
                    word_idx <= word_idx + 1'b1;
                    wr_addr  <= wr_addr + vdma_pkg::mem_addr_t'(`VDMA_ADDR_STEP);
                end
            end
        end
    end

    // slot fill, upper byte of each slot zero
    always_ff @(posedge app_clk) begin
        if (pix_fire)
            wr_data[slot*`VDMA_SLOT_W +: `VDMA_SLOT_W] <=
                {{(`VDMA_SLOT_W - `VDMA_PIX_W){1'b0}}, pix_data};
    end

endmodule

// ==== vdma/frame_reader.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reads the frame buffer ahead of the display and unpacks pixels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "vdma_params.svh"

module frame_reader (
    input  logic                app_clk,
    input  logic                rst,
    input  logic                frame_written,
    output logic                rd_req,
    output vdma_pkg::mem_addr_t rd_addr,
    input  logic                rd_done,
    input  vdma_pkg::mem_word_t app_rd_data,
    input  logic                app_rd_data_valid,
    output logic                vid_valid,
    input  logic                vid_ready,
    output vdma_pkg::pixel_t    vid_data
);

    localparam int DEPTH = `VDMA_RD_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int SL_W  = $clog2(`VDMA_PIX_PER_WORD);
    localparam int WORDS = `VDMA_H_ACTIVE * `VDMA_V_ACTIVE / `VDMA_PIX_PER_WORD;
    localparam logic [SL_W-1:0]  LAST_SLOT = SL_W'(`VDMA_PIX_PER_WORD - 1);
    localparam vdma_pkg::coord_t LAST_WORD = vdma_pkg::coord_t'(WORDS - 1);
    localparam logic [CNT_W:0]   DEPTH_V   = (CNT_W + 1)'(DEPTH);

    vdma_pkg::mem_word_t fifo_mem [DEPTH];
    logic [PTR_W-1:0]    wptr;
    logic [PTR_W-1:0]    rptr;
    logic [CNT_W-1:0]    fifo_cnt;  // words held
    logic [CNT_W-1:0]    pend;      // issued, not yet returned
    logic [CNT_W:0]      used;
    logic [SL_W-1:0]     slot;      // pixel within head word
    vdma_pkg::coord_t    word_idx;
    logic                pop;

    assign used      = pend + fifo_cnt;
    assign vid_valid = (fifo_cnt != '0);
    assign vid_data  = fifo_mem[rptr][slot*`VDMA_SLOT_W +: `VDMA_PIX_W];
    assign pop       = vid_valid && vid_ready && (slot == LAST_SLOT);

    always_ff @(posedge app_clk) begin
        if (rst) begin
            rd_req   <= 1'b0;
            rd_addr  <= vdma_pkg::mem_addr_t'(`VDMA_FB_BASE);
            word_idx <= '0;
            pend     <= '0;
            fifo_cnt <= '0;
            wptr     <= '0;
            rptr     <= '0;
            slot     <= '0;
        end else begin
            // one read in flight at a time, only with room reserved
            if (!rd_req && frame_written && used < DEPTH_V)
                rd_req <= 1'b1;
            if (rd_done) begin
                rd_req <= 1'b0;
                if (word_idx == LAST_WORD) begin
                    word_idx <= '0;
                    rd_addr  <= vdma_pkg::mem_addr_t'(`VDMA_FB_BASE);
                end else begin
                    word_idx <= word_idx + 1'b1;
                    rd_addr  <= rd_addr + vdma_pkg::mem_addr_t'(`VDMA_ADDR_STEP);
                end
            end
            case ({rd_done, app_rd_data_valid})
                2'b10:   pend <= pend + 1'b1;
                2'b01:   pend <= pend - 1'b1;
                default: pend <= pend;
            endcase
            case ({app_rd_data_valid, pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
            if (app_rd_data_valid)
                wptr <= wptr + 1'b1;
            if (pop)
                rptr <= rptr + 1'b1;
            if (vid_valid && vid_ready)
                slot <= (slot == LAST_SLOT) ? '0 : slot + 1'b1;
        end
    end

    always_ff @(posedge app_clk) begin
        if (app_rd_data_valid)
            fifo_mem[wptr] <= app_rd_data;
    end

    // returned data must always find a free entry
    assert property (@(posedge app_clk) disable iff (rst)
        app_rd_data_valid |-> (pend != '0) && (fifo_cnt < CNT_W'(DEPTH)));

endmodule

// ==== vdma/mem_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shares the native app port, reader first, one command at a time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                app_clk,
    input  logic                rst,
    input  logic                wr_req,
    input  vdma_pkg::mem_addr_t wr_addr,
    input  vdma_pkg::mem_word_t wr_data,
    output logic                wr_done,
    input  logic                rd_req,
    input  vdma_pkg::mem_addr_t rd_addr,
    output logic                rd_done,
    output vdma_pkg::mem_addr_t app_addr,
    output vdma_pkg::mem_cmd_e  app_cmd,
    output logic                app_en,
    output vdma_pkg::mem_word_t app_wdf_data,
    output logic                app_wdf_end,
    output vdma_pkg::wr_mask_t  app_wdf_mask,
    output logic                app_wdf_wren,
    input  logic                app_rdy,
    input  logic                app_wdf_rdy
);

    typedef enum logic [1:0] {IDLE, CMD, WAIT_DATA} state_e;

    state_e state;
    logic   cmd_left;   // command still waiting on app_rdy
    logic   dat_left;   // write data still waiting on app_wdf_rdy
    logic   finish;

    assign cmd_left = app_en && !app_rdy;
    assign dat_left = app_wdf_wren && !app_wdf_rdy;
    assign finish   = (state != IDLE) && !cmd_left && !dat_left;

    // done on the accepting cycle, so the request drops before IDLE looks again
    assign rd_done = finish && (app_cmd == vdma_pkg::CMD_READ);
    assign wr_done = finish && (app_cmd == vdma_pkg::CMD_WRITE);

    assign app_wdf_end  = app_wdf_wren; // single beat per write
    assign app_wdf_mask = '0;

    always_ff @(posedge app_clk) begin
        if (rst) begin
            state        <= IDLE;
            app_en       <= 1'b0;
            app_wdf_wren <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (rd_req || wr_req) begin
                        state  <= CMD;
                        app_en <= 1'b1;
                    end
                    if (!rd_req && wr_req)
                        app_wdf_wren <= 1'b1;
                end
                CMD: begin
                    if (app_rdy)
                        app_en <= 1'b0;
                    if (app_wdf_rdy)
                        app_wdf_wren <= 1'b0;
                    if (finish)
                        state <= IDLE;
                    else if (!cmd_left)
                        state <= WAIT_DATA;  // command in, data pending
                end
                WAIT_DATA: begin
                    if (app_wdf_rdy)
                        app_wdf_wren <= 1'b0;
                    if (finish)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // latch the granted request
    always_ff @(posedge app_clk) begin
        if (state == IDLE) begin
            if (rd_req) begin
                app_addr <= rd_addr;
                app_cmd  <= vdma_pkg::CMD_READ;
            end else if (wr_req) begin
                app_addr     <= wr_addr;
                app_cmd      <= vdma_pkg::CMD_WRITE;
                app_wdf_data <= wr_data;
            end
        end
    end

    // command held unchanged until the controller takes it
    assert property (@(posedge app_clk) disable iff (rst)
        app_en && !app_rdy |=> app_en && $stable(app_addr));

endmodule

// ==== rtl/video_out.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster timing and registered hdmi outputs, starts on first pixel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "vdma_params.svh"

module video_out (
    input  logic             app_clk,
    input  logic             rst,
    input  logic             vid_valid,
    output logic             vid_ready,
    input  vdma_pkg::pixel_t vid_data,
    output logic             hdmi_vs,
    output logic             hdmi_hs,
    output logic             hdmi_de,
    output vdma_pkg::pixel_t hdmi_data,
    output logic             led
);

    logic             started;
    vdma_pkg::coord_t h;            // column
    vdma_pkg::coord_t v;            // line
    vdma_pkg::coord_t underflow_cnt;
    logic             active;
    logic             hs_now;
    logic             vs_now;

    assign active    = started && (h < `VDMA_H_ACTIVE) && (v < `VDMA_V_ACTIVE);
    assign hs_now    = started && (h >= `VDMA_HS_START)
                     && (h < `VDMA_HS_START + `VDMA_HS_LEN);
    assign vs_now    = started && (v >= `VDMA_V_ACTIVE)
                     && (v < `VDMA_V_ACTIVE + `VDMA_VS_LINES);
    assign vid_ready = active;      // take a pixel on every active cycle

    always_ff @(posedge app_clk) begin
        if (rst) begin
            started       <= 1'b0;
            h             <= '0;
            v             <= '0;
            underflow_cnt <= '0;
            hdmi_vs       <= 1'b0;
            hdmi_hs       <= 1'b0;
            hdmi_de       <= 1'b0;
            led           <= 1'b0;
        end else begin
            if (!started) begin
                started <= vid_valid;   // raster begins next cycle at 0,0
                h       <= '0;
                v       <= '0;
            end else if (h == `VDMA_H_TOTAL - 1) begin
                h <= '0;
                v <= (v == `VDMA_V_TOTAL - 1) ? '0 : v + 1'b1;
            end else begin
                h <= h + 1'b1;
            end
            if (active && !vid_valid)
                underflow_cnt <= underflow_cnt + 1'b1;
            hdmi_vs <= vs_now;
            hdmi_hs <= hs_now;
            hdmi_de <= active;
            led     <= vs_now;          // blinks with vsync
        end
    end

    // black outside active area and on a missing pixel
    always_ff @(posedge app_clk) begin
        hdmi_data <= (active && vid_valid) ? vid_data : '0;
    end

    assert property (@(posedge app_clk) disable iff (rst) underflow_cnt == '0);

endmodule

// ==== rtl/video_test_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame buffer test top, pattern in, native app port, hdmi out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "vdma_params.svh"

module video_test_top (
    input  logic                        app_clk,
    input  logic                        rst,
    input  logic                        init_calib_complete,
    output logic [`VDMA_MEM_AW-1:0]     app_addr,
    output logic [2:0]                  app_cmd,
    output logic                        app_en,
    output logic [`VDMA_MEM_DW-1:0]     app_wdf_data,
    output logic                        app_wdf_end,
    output logic [`VDMA_MEM_DW/8-1:0]   app_wdf_mask,
    output logic                        app_wdf_wren,
    input  logic [`VDMA_MEM_DW-1:0]     app_rd_data,
    input  logic                        app_rd_data_valid,
    input  logic                        app_rdy,
    input  logic                        app_wdf_rdy,
    output logic                        hdmi_vs,
    output logic                        hdmi_hs,
    output logic                        hdmi_de,
    output logic [`VDMA_PIX_W-1:0]      hdmi_data,
    output logic                        led
);

    logic                      pix_valid, pix_ready;
    logic [`VDMA_PIX_W-1:0]    pix_data;
    logic                      wr_req, wr_done, frame_written;
    logic [`VDMA_MEM_AW-1:0]   wr_addr;
    logic [`VDMA_MEM_DW-1:0]   wr_data;
    logic                      rd_req, rd_done;
    logic [`VDMA_MEM_AW-1:0]   rd_addr;
    logic                      vid_valid, vid_ready;
    logic [`VDMA_PIX_W-1:0]    vid_data;

    pattern_gen u_pattern_gen (
        .app_clk, .rst, .init_calib_complete,
        .pix_valid, .pix_ready, .pix_data
    );

    frame_writer u_frame_writer (
        .app_clk, .rst, .pix_valid, .pix_ready, .pix_data,
        .wr_req, .wr_addr, .wr_data, .wr_done, .frame_written
    );

    frame_reader u_frame_reader (
        .app_clk, .rst, .frame_written, .rd_req, .rd_addr, .rd_done,
        .app_rd_data, .app_rd_data_valid, .vid_valid, .vid_ready, .vid_data
    );

    mem_arbiter u_mem_arbiter (
        .app_clk, .rst, .wr_req, .wr_addr, .wr_data, .wr_done,
        .rd_req, .rd_addr, .rd_done, .app_addr, .app_cmd, .app_en,
        .app_wdf_data, .app_wdf_end, .app_wdf_mask, .app_wdf_wren,
        .app_rdy, .app_wdf_rdy
    );

    video_out u_video_out (
        .app_clk, .rst, .vid_valid, .vid_ready, .vid_data,
        .hdmi_vs, .hdmi_hs, .hdmi_de, .hdmi_data, .led
    );

endmodule

// ==== dv/frame_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// watches the DUT ports and checks writes, raster and pixels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "vdma_params.svh"

module frame_checker (
    input logic                      app_clk,
    input logic                      rst,
    input logic                      init_calib_complete,
    input logic [`VDMA_MEM_AW-1:0]   app_addr,
    input logic [2:0]                app_cmd,
    input logic                      app_en,
    input logic [`VDMA_MEM_DW-1:0]   app_wdf_data,
    input logic                      app_wdf_end,
    input logic [`VDMA_MEM_DW/8-1:0] app_wdf_mask,
    input logic                      app_wdf_wren,
    input logic                      app_wdf_rdy,
    input logic                      hdmi_vs,
    input logic                      hdmi_hs,
    input logic                      hdmi_de,
    input logic [`VDMA_PIX_W-1:0]    hdmi_data,
    input logic                      led
);

    int check_cnt = 0;
    int err_cnt = 0;
    int frames_done = 0;    // complete frames seen this row
    int row_checks = 0;     // snapshots at row start
    int row_errs = 0;
    int rows_done = 0;
    int x, y;               // position inside the frame
    int de_run, hs_run, vs_run;
    logic armed;            // set on the first vsync fall
    logic prev_de, prev_hs, prev_vs;
    int k;

    // red = line, green = column, blue = inverted column
    function automatic logic [23:0] pattern_pixel(input int col, input int line);
        logic [7:0] c;
        c = col[7:0];
        return {line[7:0], c, ~c};
    endfunction

    function automatic logic [127:0] expected_word(input int idx);
        logic [127:0] w;
        int p;
        w = '0;
        for (int n = 0; n < 4; n++) begin
            p = idx * 4 + n;
            w[n*32 +: 32] = {8'h00, pattern_pixel(p % `VDMA_H_ACTIVE, p / `VDMA_H_ACTIVE)};
        end
        return w;
    endfunction

    task automatic compare_value(input string name, input logic [127:0] exp,
                                 input logic [127:0] got);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Error: %s expected %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic flag_failure(input string what);
        check_cnt++;
        err_cnt++;
        $display("%s at %0t", what, $time);
    endtask

    // sampled on the falling edge when DUT outputs have settled
    always @(negedge app_clk) begin
        if (rst) begin
            armed = 1'b0;
            x = 0;
            y = 0;
            de_run = 0;
            hs_run = 0;
            vs_run = 0;
            frames_done = 0;
            prev_de = 1'b0;
            prev_hs = 1'b0;
            prev_vs = 1'b0;
        end else begin
            if (!init_calib_complete) begin     // quiet until calibration
                compare_value("app_en", 0, app_en);
                compare_value("app_wdf_wren", 0, app_wdf_wren);
                compare_value("hdmi_de", 0, hdmi_de);
                compare_value("hdmi_hs", 0, hdmi_hs);
                compare_value("hdmi_vs", 0, hdmi_vs);
                compare_value("led", 0, led);
            end
            compare_value("led", hdmi_vs, led);
            // accepted write data against the packed pattern
            if (app_wdf_wren && app_wdf_rdy) begin
                compare_value("app_cmd", 0, app_cmd);
                compare_value("app_wdf_end", 1, app_wdf_end);   // single beat
                compare_value("app_wdf_mask", 0, app_wdf_mask); // all bytes written
                k = (int'(app_addr) - `VDMA_FB_BASE) / `VDMA_ADDR_STEP;
                if (app_addr < `VDMA_FB_BASE || k >= 16
                    || (int'(app_addr) - `VDMA_FB_BASE) % `VDMA_ADDR_STEP != 0)
                    flag_failure("write landed outside the frame buffer");
                else
                    compare_value("app_wdf_data", expected_word(k), app_wdf_data);
            end
            if (hdmi_de) begin
                de_run++;
                if (hdmi_vs)
                    flag_failure("data enable high during vsync");
                if (armed) begin
                    compare_value("hdmi_data", pattern_pixel(x, y), hdmi_data);
                    x++;
                    if (x == `VDMA_H_ACTIVE) begin
                        x = 0;
                        y++;
                    end
                end
            end else if (prev_de) begin
                compare_value("hdmi_de run", `VDMA_H_ACTIVE, de_run);
                de_run = 0;
            end
            if (hdmi_hs)
                hs_run++;
            else if (prev_hs) begin
                compare_value("hdmi_hs width", `VDMA_HS_LEN, hs_run);
                hs_run = 0;
            end
            if (hdmi_vs) begin
                if (!prev_vs && armed) begin    // frame just closed
                    if (y != `VDMA_V_ACTIVE || x != 0)
                        flag_failure($sformatf("frame ended after %0d lines", y));
                    else
                        frames_done++;
                end
                vs_run++;
            end else if (prev_vs) begin
                compare_value("hdmi_vs width", `VDMA_H_TOTAL * `VDMA_VS_LINES, vs_run);
                vs_run = 0;
                armed = 1'b1;
                x = 0;
                y = 0;
            end
            prev_de = hdmi_de;
            prev_hs = hdmi_hs;
            prev_vs = hdmi_vs;
        end
    end

    task automatic close_row(input int row, input int calib, input int dens,
                             input int frames);
        $display("row %0d calib %0d density %0d/8 frames %0d: %0d checks, %0d errors",
                 row, calib, dens, frames, check_cnt - row_checks, err_cnt - row_errs);
        row_checks = check_cnt;
        row_errs = err_cnt;
        rows_done++;
    endtask

    task automatic print_totals();
        $display("rows %0d, checks %0d, errors %0d", rows_done, check_cnt, err_cnt);
    endtask

endmodule

// ==== dv/tb_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench top, native port memory model and row table loop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "vdma_params.svh"

module tb_top;

    localparam int ROWS = 3;
    localparam int FRAME_CYC = `VDMA_H_TOTAL * `VDMA_V_TOTAL;

    // calib delay, ready density out of 8, frames to see
    int calib_dly [ROWS] = '{5, 20, 12};
    int density   [ROWS] = '{8, 7, 6};
    int frames    [ROWS] = '{3, 3, 4};

    logic                    app_clk = 1'b0;
    logic                    rst;
    logic                    init_calib_complete;
    logic [`VDMA_MEM_AW-1:0] app_addr;
    logic [2:0]              app_cmd;
    logic                    app_en;
    logic [`VDMA_MEM_DW-1:0] app_wdf_data;
    logic                    app_wdf_end;
    logic [15:0]             app_wdf_mask;
    logic                    app_wdf_wren;
    logic [`VDMA_MEM_DW-1:0] app_rd_data;
    logic                    app_rd_data_valid;
    logic                    app_rdy;
    logic                    app_wdf_rdy;
    logic                    hdmi_vs, hdmi_hs, hdmi_de, led;
    logic [`VDMA_PIX_W-1:0]  hdmi_data;

    logic [`VDMA_MEM_DW-1:0] mem [logic [`VDMA_MEM_AW-1:0]];
    logic [`VDMA_MEM_AW-1:0] rd_q [$];      // read addresses in order
    int unsigned             rd_due [$];    // cycle each one returns
    int unsigned             cyc = 0;
    int unsigned             limit;
    logic [31:0]             lfsr;
    int                      cur_density;
    int                      rnd;

    always #10 app_clk = ~app_clk;

    video_test_top u_dut (.*);

    frame_checker u_chk (
        .app_clk, .rst, .init_calib_complete, .app_addr, .app_cmd, .app_en,
        .app_wdf_data, .app_wdf_end, .app_wdf_mask, .app_wdf_wren, .app_wdf_rdy,
        .hdmi_vs, .hdmi_hs, .hdmi_de, .hdmi_data, .led
    );

    // galois form with taps 32 30 26 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);     // one step per bit
        end
    endtask

    // accept commands and write data mid cycle
    always @(negedge app_clk) begin
        if (rst) begin
            rd_q.delete();
            rd_due.delete();
        end else begin
            if (app_en && app_rdy && app_cmd == 3'd1) begin
                rd_q.push_back(app_addr);
                rd_due.push_back(cyc + 4);
            end
            if (app_wdf_wren && app_wdf_rdy)
                mem[app_addr] = app_wdf_data;
        end
    end

    // read return and random ready just after the edge
    always @(posedge app_clk) begin
        cyc = cyc + 1;
        #1;
        app_rd_data_valid = 1'b0;
        if (rd_due.size() > 0 && rd_due[0] <= cyc) begin
            app_rd_data = mem.exists(rd_q[0]) ? mem[rd_q[0]] : '0;
            app_rd_data_valid = 1'b1;
            void'(rd_q.pop_front());
            void'(rd_due.pop_front());
        end
        draw_bits(3, rnd);
        app_rdy = rnd < cur_density;
        draw_bits(3, rnd);
        app_wdf_rdy = rnd < cur_density;
    end

    always @(posedge app_clk) begin
        if (cyc > limit) begin
            $display("timeout after %0d cycles, frames did not arrive", cyc);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        init_calib_complete = 1'b0;
        app_rd_data = '0;
        app_rd_data_valid = 1'b0;
        app_rdy = 1'b0;
        app_wdf_rdy = 1'b0;
        lfsr = 32'h1663e6ce;
        cur_density = 8;
        limit = 0;
        for (int r = 0; r < ROWS; r++)  // frames plus priming per row
            limit += (frames[r] + 3) * FRAME_CYC + calib_dly[r] + 200;
        for (int r = 0; r < ROWS; r++) begin
            @(posedge app_clk);
            #1;
            rst = 1'b1;
            init_calib_complete = 1'b0;
            cur_density = density[r];
            repeat (3) @(posedge app_clk);
            #1;
            rst = 1'b0;
            repeat (calib_dly[r]) @(posedge app_clk);
            #1;
            init_calib_complete = 1'b1;
            while (u_chk.frames_done < frames[r])
                @(posedge app_clk);
            u_chk.close_row(r, calib_dly[r], density[r], frames[r]);
        end
        u_chk.print_totals();
        if (u_chk.err_cnt == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+common
common/vdma_pkg.sv
rtl/pattern_gen.sv
vdma/frame_writer.sv
vdma/frame_reader.sv
vdma/mem_arbiter.sv
rtl/video_out.sv
rtl/video_test_top.sv
dv/frame_checker.sv
dv/tb_top.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module tb_top -Mdir obj_dir
	-./obj_dir/Vtb_top > sim.log 2>&1
	@cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then exit 1; fi
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
